// File: fp_mul_16x8.f
hw/fp_mul_pkg.sv
hw/operand_decode.sv
hw/product_tree.sv
hw/normalize_pack.sv
hw/fp_mul_16x8.sv
verification/fp_mul_chk.sv
verification/fp_mul_checker.sv
verification/tb_fp_mul_16x8.sv

// File: hw/fp_mul_16x8.sv
`timescale 1ns/1ps

module fp_mul_16x8
(
  input  logic              CLK,
  input  logic              Reset,
  input  fp_mul_pkg::half_t a,
  input  fp_mul_pkg::mini_t b,
  output fp_mul_pkg::half_t result
);

  import fp_mul_pkg::*;

  // stage 1 outputs
  half_sig_t sig_a;
  mini_sig_t sig_b;
  exp_sum_t  exp_sum;
  logic      sign;
  logic      is_zero;
  logic      is_inf;

  // stage 5 outputs
  raw_prod_t prod;
  exp_sum_t  exp_sum_d;
  logic      sign_d;
  logic      zero_d;
  logic      inf_d;

  // stage 1, field split and exponent sum
  operand_decode u_decode
  (
    .CLK     (CLK),
    .Reset   (Reset),
    .a       (a),
    .b       (b),
    .sig_a   (sig_a),
    .sig_b   (sig_b),
    .exp_sum (exp_sum),
    .sign    (sign),
    .is_zero (is_zero),
    .is_inf  (is_inf)
  );

  // stages 2 to 5, shift and add tree
  product_tree u_tree
  (
    .CLK       (CLK),
    .Reset     (Reset),
    .sig_a     (sig_a),
    .sig_b     (sig_b),
    .exp_sum   (exp_sum),
    .sign      (sign),
    .is_zero   (is_zero),
    .is_inf    (is_inf),
    .prod      (prod),
    .exp_sum_d (exp_sum_d),
    .sign_d    (sign_d),
    .zero_d    (zero_d),
    .inf_d     (inf_d)
  );

  // stage 6, normalize and pack
  normalize_pack u_pack
  (
    .CLK       (CLK),
    .Reset     (Reset),
    .prod      (prod),
    .exp_sum_d (exp_sum_d),
    .sign_d    (sign_d),
    .zero_d    (zero_d),
    .inf_d     (inf_d),
    .result    (result)
  );

endmodule

// File: hw/fp_mul_pkg.sv
package fp_mul_pkg;

  ////////////////////////////////////////
  // operand formats
  ////////////////////////////////////////

  // half precision, 1 sign + 5 exp + 10 frac
  localparam int HALF_EXP_W  = 5;
  localparam int HALF_FRAC_W = 10;

  // minifloat, 1 sign + 3 exp + 4 frac
  localparam int MINI_EXP_W  = 3;
  localparam int MINI_FRAC_W = 4;

  // exponent biases
  localparam int HALF_BIAS = 15;
  localparam int MINI_BIAS = 3;

  // all ones exponent, infinity code of the half format
  localparam int HALF_EXP_MAX = 31;

  // raw significand product, 11 x 5 bits
  localparam int PROD_W = 16;

  // register stages from input pins to result
  localparam int PIPE_DEPTH = 6;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  typedef logic [HALF_EXP_W+HALF_FRAC_W:0] half_t;
  typedef logic [MINI_EXP_W+MINI_FRAC_W:0] mini_t;
  typedef logic [HALF_EXP_W-1:0]           half_exp_t;
  // significands carry the hidden bit on top
  typedef logic [HALF_FRAC_W:0]            half_sig_t;
  typedef logic [MINI_FRAC_W:0]            mini_sig_t;
  // biased sum, signed so underflow stays visible below zero
  typedef logic signed [6:0]               exp_sum_t;
  typedef logic [PROD_W-1:0]               raw_prod_t;

endpackage

// File: hw/normalize_pack.sv
`timescale 1ns/1ps

module normalize_pack
(
  input  logic                  CLK,
  input  logic                  Reset,
  input  fp_mul_pkg::raw_prod_t prod,
  input  fp_mul_pkg::exp_sum_t  exp_sum_d,
  input  logic                  sign_d,
  input  logic                  zero_d,
  input  logic                  inf_d,
  output fp_mul_pkg::half_t     result
);

  import fp_mul_pkg::*;

  // leading zeros of the raw product
  logic [3:0]             lead_zeros;
  // product with its leading one at the top bit
  raw_prod_t              norm;
  // biased result exponent after normalization
  exp_sum_t               exp_norm;
  // right shift for the subnormal range
  exp_sum_t               sub_shift;
  raw_prod_t              sub_frac;
  logic [HALF_FRAC_W-1:0] frac_norm;
  half_t                  result_c;

  ////////////////////////////////////////
  // leading one detect
  ////////////////////////////////////////

  // highest set bit wins, scan runs upward
  always_comb
  begin
    lead_zeros = 4'(PROD_W - 1);
    for (int i = 0; i < PROD_W; i++)
    begin
      if (prod[i])
      begin
        lead_zeros = 4'(PROD_W - 1 - i);
      end
    end
  end

  assign norm = prod << lead_zeros;

  // product lsb weighs 2^(exp_sum-14), so a top-bit one gives exp_sum+16 biased
  assign exp_norm = exp_sum_d + exp_sum_t'(PROD_W) - exp_sum_t'(lead_zeros);

  // 10 bits under the leading one, rest truncated
  assign frac_norm = norm[PROD_W-2 -: HALF_FRAC_W];

  ////////////////////////////////////////
  // subnormal path
  ////////////////////////////////////////

  // exponent 0 needs a shift of 6, one more per step below
  assign sub_shift = exp_sum_t'(PROD_W - HALF_FRAC_W) - exp_norm;

  // shifts past the width flush to zero
  assign sub_frac = norm >> sub_shift;

  ////////////////////////////////////////
  // special cases and packing
  ////////////////////////////////////////

  always_comb
  begin
    // zero flag, or the empty product that reset leaves in the pipe
    if (zero_d || (prod == '0))
    begin
      // zero beats infinity, sign kept
      result_c = {sign_d, {(HALF_EXP_W + HALF_FRAC_W){1'b0}}};
    end
    else if (inf_d || (exp_norm >= exp_sum_t'(HALF_EXP_MAX)))
    begin
      // saturate, magnitude reached 2^16
      result_c = {sign_d, half_exp_t'(HALF_EXP_MAX), {HALF_FRAC_W{1'b0}}};
    end
    else if (exp_norm <= 0)
    begin
      // subnormal or underflow to zero
      result_c = {sign_d, half_exp_t'(0), sub_frac[HALF_FRAC_W-1:0]};
    end
    else
    begin
      result_c = {sign_d, exp_norm[HALF_EXP_W-1:0], frac_norm};
    end
  end

  // stage 6, output register
  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
    begin
      result <= '0;
    end
    else
    begin
      result <= result_c;
    end
  end

endmodule

// File: hw/operand_decode.sv
`timescale 1ns/1ps

module operand_decode
(
  input  logic                  CLK,
  input  logic                  Reset,
  input  fp_mul_pkg::half_t     a,
  input  fp_mul_pkg::mini_t     b,
  output fp_mul_pkg::half_sig_t sig_a,
  output fp_mul_pkg::mini_sig_t sig_b,
  output fp_mul_pkg::exp_sum_t  exp_sum,
  output logic                  sign,
  output logic                  is_zero,
  output logic                  is_inf
);

  import fp_mul_pkg::*;

  // raw fields of both operands
  logic                   sign_a;
  half_exp_t              exp_a;
  logic [HALF_FRAC_W-1:0] frac_a;
  logic                   sign_b;
  logic [MINI_EXP_W-1:0]  exp_b;
  logic [MINI_FRAC_W-1:0] frac_b;

  // effective exponents and stage 1 inputs
  half_exp_t              eff_a;
  logic [MINI_EXP_W-1:0]  eff_b;
  exp_sum_t               exp_sum_c;
  logic                   zero_c;
  logic                   inf_c;

  assign {sign_a, exp_a, frac_a} = a;
  assign {sign_b, exp_b, frac_b} = b;

  // subnormal operands use exponent 1 with a hidden bit of 0
  assign eff_a = (exp_a == '0) ? half_exp_t'(1) : exp_a;
  assign eff_b = (exp_b == '0) ? MINI_EXP_W'(1) : exp_b;

  // unbiased sum of both exponents, may go negative
  assign exp_sum_c = exp_sum_t'(eff_a) + exp_sum_t'(eff_b)
                   - exp_sum_t'(HALF_BIAS + MINI_BIAS);

  // either operand zero forces a zero result
  assign zero_c = ((exp_a == '0) && (frac_a == '0)) || ((exp_b == '0) && (frac_b == '0));

  // only the half operand has an infinity code
  assign inf_c = (exp_a == half_exp_t'(HALF_EXP_MAX)) && (frac_a == '0);

  ////////////////////////////////////////
  // stage 1 register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
    begin
      sig_a   <= '0;
      sig_b   <= '0;
      exp_sum <= '0;
      sign    <= 1'b0;
      is_zero <= 1'b0;
      is_inf  <= 1'b0;
    end
    else
    begin
      // hidden bit set for a nonzero exponent field
      sig_a   <= {|exp_a, frac_a};
      sig_b   <= {|exp_b, frac_b};
      exp_sum <= exp_sum_c;
      sign    <= sign_a ^ sign_b;
      is_zero <= zero_c;
      is_inf  <= inf_c;
    end
  end

endmodule

// File: hw/product_tree.sv
`timescale 1ns/1ps

module product_tree
(
  input  logic                  CLK,
  input  logic                  Reset,
  input  fp_mul_pkg::half_sig_t sig_a,
  input  fp_mul_pkg::mini_sig_t sig_b,
  input  fp_mul_pkg::exp_sum_t  exp_sum,
  input  logic                  sign,
  input  logic                  is_zero,
  input  logic                  is_inf,
  output fp_mul_pkg::raw_prod_t prod,
  output fp_mul_pkg::exp_sum_t  exp_sum_d,
  output logic                  sign_d,
  output logic                  zero_d,
  output logic                  inf_d
);

  import fp_mul_pkg::*;

  // one row per bit of the minifloat significand
  raw_prod_t pp_c  [MINI_FRAC_W:0];
  raw_prod_t pp_q  [MINI_FRAC_W:0];
  // adder tree levels, 5 rows -> 3 -> 2 -> 1
  raw_prod_t lvl3_q [2:0];
  raw_prod_t lvl4_q [1:0];

  // side-band delay line for stages 2 to 4
  exp_sum_t  exp_pipe [2:0];
  logic [2:0] sign_pipe;
  logic [2:0] zero_pipe;
  logic [2:0] inf_pipe;

  // shifted copy of sig_a where sig_b has a one
  always_comb
  begin
    for (int i = 0; i <= MINI_FRAC_W; i++)
    begin
      pp_c[i] = sig_b[i] ? (raw_prod_t'(sig_a) << i) : '0;
    end
  end

  ////////////////////////////////////////
  // stages 2 to 5, shift and add
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
    begin
      for (int i = 0; i <= MINI_FRAC_W; i++)
      begin
        pp_q[i] <= '0;
      end
      lvl3_q[0] <= '0;
      lvl3_q[1] <= '0;
      lvl3_q[2] <= '0;
      lvl4_q[0] <= '0;
      lvl4_q[1] <= '0;
      prod      <= '0;
    end
    else
    begin
      // stage 2, masked partial products
      for (int i = 0; i <= MINI_FRAC_W; i++)
      begin
        pp_q[i] <= pp_c[i];
      end
      // stage 3, pairwise sums, odd row passes
      lvl3_q[0] <= pp_q[0] + pp_q[1];
      lvl3_q[1] <= pp_q[2] + pp_q[3];
      lvl3_q[2] <= pp_q[4];
      // stage 4
      lvl4_q[0] <= lvl3_q[0] + lvl3_q[1];
      lvl4_q[1] <= lvl3_q[2];
      // stage 5, full product, never exceeds 16 bits
      prod      <= lvl4_q[0] + lvl4_q[1];
    end
  end

  // side-band fields in lockstep with the tree
  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
    begin
      exp_pipe[0] <= '0;
      exp_pipe[1] <= '0;
      exp_pipe[2] <= '0;
      sign_pipe   <= '0;
      zero_pipe   <= '0;
      inf_pipe    <= '0;
      exp_sum_d   <= '0;
      sign_d      <= 1'b0;
      zero_d      <= 1'b0;
      inf_d       <= 1'b0;
    end
    else
    begin
      exp_pipe[0] <= exp_sum;
      exp_pipe[1] <= exp_pipe[0];
      exp_pipe[2] <= exp_pipe[1];
      sign_pipe   <= {sign_pipe[1:0], sign};
      zero_pipe   <= {zero_pipe[1:0], is_zero};
      inf_pipe    <= {inf_pipe[1:0], is_inf};
      // stage 5 outputs line up with prod
      exp_sum_d   <= exp_pipe[2];
      sign_d      <= sign_pipe[2];
      zero_d      <= zero_pipe[2];
      inf_d       <= inf_pipe[2];
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the fp_mul_16x8 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f fp_mul_16x8.f \
  --top-module tb_fp_mul_16x8 \
  -Mdir obj_dir -o sim_fp_mul_16x8
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_fp_mul_16x8)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TEST OK'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/fp_mul_checker.sv
`timescale 1ns/1ps

module fp_mul_checker
(
  input  logic              CLK,
  input  logic              Reset,
  input  fp_mul_pkg::half_t a,
  input  fp_mul_pkg::mini_t b,
  input  fp_mul_pkg::half_t result,
  input  logic [2:0]        test_id,
  input  logic              test_last,
  output int                checks,
  output int                errors,
  output int                tests_done
);

  import fp_mul_pkg::*;

  // pairs in flight, oldest first
  half_t      exp_q  [$];
  half_t      a_q    [$];
  mini_t      b_q    [$];
  logic [2:0] id_q   [$];
  logic       last_q [$];

  // running counts, per test and overall
  int         test_checks [0:6];
  int         test_errors [0:6];
  int         n_checks = 0;
  int         n_errors = 0;
  int         n_done   = 0;
  // set once a clocked reset edge has cleared the output register
  logic       reset_seen = 1'b0;

  // popped entry
  half_t      want;
  half_t      op_a;
  mini_t      op_b;
  logic [2:0] id;
  logic       last;

  function automatic real pow2(int n);
    real r;
    int  i;
    r = 1.0;
    for (i = 0; i < n; i++)
      r = r * 2.0;
    for (i = 0; i < -n; i++)
      r = r / 2.0;
    return r;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // exact real product, truncated toward zero into half precision
  function automatic half_t ref_mul(half_t x, mini_t y);
    logic s;
    int   ex;
    int   fx;
    int   ey;
    int   fy;
    int   e;
    int   m;
    real  mag_x;
    real  mag_y;
    real  mag;
    s  = x[15] ^ y[7];
    ex = int'(x[14:10]);
    fx = int'(x[9:0]);
    ey = int'(y[6:4]);
    fy = int'(y[3:0]);
    if ((x[14:0] == 15'd0) || (y[6:0] == 7'd0))
      return {s, 15'd0};
    if (ex == HALF_EXP_MAX)
      return {s, 5'h1f, 10'd0};
    // subnormal operands scale like exponent code 1
    if (ex == 0)
      mag_x = $itor(fx) * pow2(1 - HALF_BIAS - HALF_FRAC_W);
    else
      mag_x = $itor(fx + 1024) * pow2(ex - HALF_BIAS - HALF_FRAC_W);
    if (ey == 0)
      mag_y = $itor(fy) * pow2(1 - MINI_BIAS - MINI_FRAC_W);
    else
      mag_y = $itor(fy + 16) * pow2(ey - MINI_BIAS - MINI_FRAC_W);
    mag = mag_x * mag_y;
    if (mag >= 65536.0)
      return {s, 5'h1f, 10'd0};
    // below 2^-14, count units of 2^-24
    if (mag < pow2(-14))
    begin
      m = $rtoi(mag * pow2(24));
      return {s, 5'd0, m[9:0]};
    end
    // smallest e with mag below 2^(e-14)
    e = 1;
    while (mag >= pow2(e - 14))
      e = e + 1;
    m = $rtoi(mag * pow2(25 - e));
    return {s, e[4:0], m[9:0]};
  endfunction

  function automatic string test_name(logic [2:0] n);
    case (n)
      3'd1:    return "normal";
      3'd2:    return "subnormal";
      3'd3:    return "overflow";
      3'd4:    return "zero";
      3'd5:    return "random";
      3'd6:    return "reset";
      default: return "idle";
    endcase
  endfunction

  task automatic compare(half_t got, half_t exp_val, logic [2:0] n, string what);
    n_checks       = n_checks + 1;
    test_checks[n] = test_checks[n] + 1;
    if (got !== exp_val)
    begin
      n_errors       = n_errors + 1;
      test_errors[n] = test_errors[n] + 1;
      $display("[FAIL] %0t: test %0d %s, expected %h, got %h",
               $time, n, what, exp_val, got);
    end
  endtask

  task automatic report(logic [2:0] n);
    $display("test %0d %s: %0d checks, %0d mismatches, %s", n, test_name(n),
             test_checks[n], test_errors[n], (test_errors[n] == 0) ? "pass" : "fail");
    n_done = n_done + 1;
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  always @(posedge CLK)
  begin
    if (Reset)
    begin
      // pipeline cleared, nothing in flight
      exp_q.delete();
      a_q.delete();
      b_q.delete();
      id_q.delete();
      last_q.delete();
      if (reset_seen)
        compare(result, 16'h0000, 3'd6, "result during reset");
      reset_seen = 1'b1;
    end
    else
    begin
      // pair sampled PIPE_DEPTH edges ago is on result now
      if (exp_q.size() == PIPE_DEPTH)
      begin
        want = exp_q.pop_front();
        op_a = a_q.pop_front();
        op_b = b_q.pop_front();
        id   = id_q.pop_front();
        last = last_q.pop_front();
        compare(result, want, id, $sformatf("a=%h b=%h", op_a, op_b));
        if (last)
          report(id);
      end
      else
      begin
        // pipe still filling, only reset state on the output
        compare(result, 16'h0000, 3'd6, "result after reset");
        if (exp_q.size() == PIPE_DEPTH - 1)
          report(3'd6);
      end
      exp_q.push_back(ref_mul(a, b));
      a_q.push_back(a);
      b_q.push_back(b);
      id_q.push_back(test_id);
      last_q.push_back(test_last);
    end
    checks     <= n_checks;
    errors     <= n_errors;
    tests_done <= n_done;
  end

endmodule

// File: verification/fp_mul_chk.sv
`timescale 1ns/1ps

module fp_mul_chk
(
  input logic              CLK,
  input logic              Reset,
  input logic              zero_d,
  input fp_mul_pkg::half_t result
);

  import fp_mul_pkg::*;

  // failed assertions so far, read by the testbench summary
  int fail_count = 0;

  ////////////////////////////////////////
  // output format rules
  ////////////////////////////////////////

  // infinity code never carries fraction bits, no NaN out
  inf_frac_zero: assert property (@(posedge CLK) disable iff (Reset)
    (result[HALF_EXP_W+HALF_FRAC_W-1:HALF_FRAC_W] == half_exp_t'(HALF_EXP_MAX))
      |-> (result[HALF_FRAC_W-1:0] == '0))
  else
  begin
    $error("infinite result %h has a nonzero fraction", result);
    fail_count = fail_count + 1;
  end

  // zero flag at stage 5 gives a signed zero one edge later
  zero_forces_zero: assert property (@(posedge CLK) disable iff (Reset)
    zero_d |=> (result[HALF_EXP_W+HALF_FRAC_W-1:0] == '0))
  else
  begin
    $error("zero operand did not give a zero result, got %h", result);
    fail_count = fail_count + 1;
  end

endmodule

// File: verification/tb_fp_mul_16x8.sv
`timescale 1ns/1ps

module tb_fp_mul_16x8;

  import fp_mul_pkg::*;

  localparam int RESET_CYCLES  = 10;
  localparam int NORMAL_RANDOM = 40;
  localparam int SUB_RANDOM    = 30;
  localparam int RANDOM_OPS    = 2000;
  localparam int DIRECTED_OPS  = 4 + NORMAL_RANDOM + 5 + SUB_RANDOM + 6 + 7;
  localparam int NUM_TESTS     = 6;
  // idle cycles at the end plus slack
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS
                                 + PIPE_DEPTH + 50;

  logic        CLK;
  logic        Reset;
  half_t       a;
  mini_t       b;
  half_t       result;
  logic [2:0]  test_id;
  logic        test_last;
  int          checks;
  int          errors;
  int          tests_done;
  int          assert_fails;
  logic [31:0] rng = 32'hf8b1;

  fp_mul_16x8 fp_mul_16x8_inst
  (
    .CLK    (CLK),
    .Reset  (Reset),
    .a      (a),
    .b      (b),
    .result (result)
  );

  fp_mul_checker result_checker
  (
    .CLK        (CLK),
    .Reset      (Reset),
    .a          (a),
    .b          (b),
    .result     (result),
    .test_id    (test_id),
    .test_last  (test_last),
    .checks     (checks),
    .errors     (errors),
    .tests_done (tests_done)
  );

  // format assertions on the output stage
  bind normalize_pack fp_mul_chk chk_inst
  (
    .CLK    (CLK),
    .Reset  (Reset),
    .zero_d (zero_d),
    .result (result)
  );

  // 10 ns clock
  initial
  begin
    CLK = 1'b0;
    forever
    begin
      #5 CLK = ~CLK;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one pair per rising edge
  task automatic send(half_t av, mini_t bv, logic [2:0] id, logic last);
    @(posedge CLK);
    a         <= av;
    b         <= bv;
    test_id   <= id;
    test_last <= last;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic run_normal();
    int          i;
    logic [2:0]  eb;
    send(16'h3C00, 8'h30, 3'd1, 1'b0);
    // 1.5 x 1.5 needs one normalization step
    send(16'h3E00, 8'h38, 3'd1, 1'b0);
    send(16'hBFFF, 8'h3F, 3'd1, 1'b0);
    send(16'h4500, 8'hC8, 3'd1, 1'b0);
    // half exponent 8..23, never leaves the normal range
    for (i = 0; i < NORMAL_RANDOM; i++)
    begin
      rng = xorshift(rng);
      eb  = (rng[22:20] == 3'd0) ? 3'd1 : rng[22:20];
      send({rng[31], 5'd8 + {1'b0, rng[19:16]}, rng[9:0]},
           {rng[23], eb, rng[27:24]}, 3'd1, i == NORMAL_RANDOM - 1);
    end
  endtask

  task automatic run_subnormal();
    int   i;
    logic [9:0] fa;
    logic [3:0] fb;
    send(16'h0001, 8'h30, 3'd1 + 3'd1, 1'b0);
    send(16'h03FF, 8'h38, 3'd2, 1'b0);
    send(16'h0400, 8'h08, 3'd2, 1'b0);
    // 2^-24 x 2^-6 underflows to zero
    send(16'h0001, 8'h01, 3'd2, 1'b0);
    send(16'h8200, 8'h18, 3'd2, 1'b0);
    for (i = 0; i < SUB_RANDOM; i++)
    begin
      rng = xorshift(rng);
      fa  = (rng[9:0] == 10'd0) ? 10'd1 : rng[9:0];
      fb  = (rng[27:24] == 4'd0) ? 4'd1 : rng[27:24];
      // subnormal side alternates between operands
      if (i % 2 == 0)
        send({rng[31], 5'd0, fa}, {rng[23], rng[22:20], fb}, 3'd2, i == SUB_RANDOM - 1);
      else
        send({rng[31], 1'b0, rng[13:10], fa}, {rng[23], 3'd0, fb}, 3'd2,
             i == SUB_RANDOM - 1);
    end
  endtask

  task automatic run_overflow();
    send(16'h7BFF, 8'h70, 3'd3, 1'b0);
    // exactly 2^16 saturates, 2^15 does not
    send(16'h7800, 8'h40, 3'd3, 1'b0);
    send(16'h7800, 8'h30, 3'd3, 1'b0);
    send(16'h7C00, 8'h30, 3'd3, 1'b0);
    send(16'hFC00, 8'h01, 3'd3, 1'b0);
    send(16'h7C00, 8'hF8, 3'd3, 1'b1);
  endtask

  task automatic run_zero();
    send(16'h0000, 8'h30, 3'd4, 1'b0);
    send(16'h8000, 8'h30, 3'd4, 1'b0);
    send(16'h3C00, 8'h00, 3'd4, 1'b0);
    send(16'h3C00, 8'h80, 3'd4, 1'b0);
    // zero wins over infinity
    send(16'h7C00, 8'h00, 3'd4, 1'b0);
    send(16'hFC00, 8'h00, 3'd4, 1'b0);
    send(16'h8000, 8'h80, 3'd4, 1'b1);
  endtask

  task automatic run_random();
    int    i;
    half_t av;
    for (i = 0; i < RANDOM_OPS; i++)
    begin
      rng = xorshift(rng);
      av  = rng[15:0];
      // NaN codes turn into infinity
      if (av[14:10] == 5'h1f)
        av[9:0] = 10'd0;
      send(av, rng[23:16], 3'd5, i == RANDOM_OPS - 1);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    Reset     = 1'b1;
    a         = '0;
    b         = '0;
    test_id   = 3'd0;
    test_last = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    Reset <= 1'b0;
    run_normal();
    run_subnormal();
    run_overflow();
    run_zero();
    run_random();
    // zero pairs keep the pipe busy while it drains
    send(16'h0000, 8'h00, 3'd0, 1'b0);
    while (tests_done < NUM_TESTS)
      @(posedge CLK);
    assert_fails = fp_mul_16x8_inst.u_pack.chk_inst.fail_count;
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
             checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0))
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // run length bound
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule
